// ==== source/stap_config.svh ====
// Configuration constants for the compact secure TAP
// Instruction width, opcode map and the default slave ID code
// Shared by the packages, the RTL and the testbench

`ifndef STAP_CONFIG_SVH
`define STAP_CONFIG_SVH

// ------------------------------
// Instruction register
// ------------------------------

// Width of the instruction register
`define STAP_IR_W 4

// Opcodes decoded by the instruction logic
`define STAP_IR_IDCODE  4'b0001
`define STAP_IR_TDR     4'b0100
`define STAP_IR_SECTDR  4'b0101
// All-ones is bypass, every unlisted code falls back to it as well
`define STAP_IR_BYPASS  4'b1111

// Fixed pattern loaded in Capture-IR, LSB must be 1 per 1149.1
`define STAP_IR_CAPTURE 4'b0001

// ------------------------------
// Identification
// ------------------------------

// Default value for the slave ID code pin, bit 0 set as 1149.1 requires
`define STAP_RESET_IDCODE 32'h1234_5679

`endif

// ==== source/tap_pkg.sv ====
// TAP controller types
// State encoding of the 1149.1 controller, the instruction code type,
// the strobe bundle sent to all registers and the data register select

`include "stap_config.svh"

package tap_pkg;

    // ------------------------------
    // Controller states
    // ------------------------------
    typedef enum logic [3:0] {
        TLR        = 4'h0,
        RTI        = 4'h1,
        SELECT_DR  = 4'h2,
        CAPTURE_DR = 4'h3,
        SHIFT_DR   = 4'h4,
        EXIT1_DR   = 4'h5,
        PAUSE_DR   = 4'h6,
        EXIT2_DR   = 4'h7,
        UPDATE_DR  = 4'h8,
        SELECT_IR  = 4'h9,
        CAPTURE_IR = 4'hA,
        SHIFT_IR   = 4'hB,
        EXIT1_IR   = 4'hC,
        PAUSE_IR   = 4'hD,
        EXIT2_IR   = 4'hE,
        UPDATE_IR  = 4'hF
    } tap_state_t;

    // Raw instruction code
    typedef logic [`STAP_IR_W-1:0] ir_code_t;

    // Strobes decoded from the current state, one per register action
    typedef struct packed {
        logic tlr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } tap_ctrl_t;

    // Data register selected by the current instruction
    typedef enum logic [1:0] {
        BYPASS = 2'd0,
        IDCODE = 2'd1,
        TDR    = 2'd2,
        SECTDR = 2'd3
    } dr_sel_t;

endpackage

// ==== source/dfx_pkg.sv ====
// DFx security and parallel test data types
// Secure policy encoding driven by the fuse controller, plus the
// payload layouts of the general TDR and the secure TDR

package dfx_pkg;

    // ------------------------------
    // Security policy
    // ------------------------------

    // Only the low codes are defined, the rest read as locked
    typedef enum logic [3:0] {
        LOCKED        = 4'b0000,
        FUNCTIONAL    = 4'b0001,
        UNLOCKED      = 4'b0010,
        MANUFACTURING = 4'b0011
    } policy_t;

    // ------------------------------
    // Parallel TDR payloads
    // ------------------------------

    // General TDR, 16 bits, shifted LSB first so value goes out first
    typedef struct packed {
        logic        enable;
        logic [2:0]  mode;
        logic [11:0] value;
    } tdr_data_t;

    // Secure TDR, 8 bits
    typedef struct packed {
        // Opens the debug path when set
        logic       debug_unlock;
        // VISA disable controls
        logic [1:0] visa_dis;
        // Reserved
        logic [4:0] spare;
    } sectdr_t;

endpackage

// ==== source/tap_fsm.sv ====
// TAP controller
// Standard 16-state 1149.1 state machine stepped by TMS on the rising
// edge of TCK, with the register strobes decoded from the current state

`timescale 1ns/1ps

module tap_fsm (
    input  logic                i_ftap_tck,
    input  logic                i_rst_n,
    input  logic                i_ftap_tms,
    output tap_pkg::tap_state_t o_state,
    output tap_pkg::tap_ctrl_t  o_ctrl
);

    tap_pkg::tap_state_t state_q;
    tap_pkg::tap_state_t state_d;

    // ------------------------------
    // Next-state table
    // ------------------------------
    always_comb begin
        case (state_q)
            tap_pkg::TLR:        state_d = i_ftap_tms ? tap_pkg::TLR        : tap_pkg::RTI;
            tap_pkg::RTI:        state_d = i_ftap_tms ? tap_pkg::SELECT_DR  : tap_pkg::RTI;
            // DR column
            tap_pkg::SELECT_DR:  state_d = i_ftap_tms ? tap_pkg::SELECT_IR  : tap_pkg::CAPTURE_DR;
            tap_pkg::CAPTURE_DR: state_d = i_ftap_tms ? tap_pkg::EXIT1_DR   : tap_pkg::SHIFT_DR;
            tap_pkg::SHIFT_DR:   state_d = i_ftap_tms ? tap_pkg::EXIT1_DR   : tap_pkg::SHIFT_DR;
            tap_pkg::EXIT1_DR:   state_d = i_ftap_tms ? tap_pkg::UPDATE_DR  : tap_pkg::PAUSE_DR;
            tap_pkg::PAUSE_DR:   state_d = i_ftap_tms ? tap_pkg::EXIT2_DR   : tap_pkg::PAUSE_DR;
            tap_pkg::EXIT2_DR:   state_d = i_ftap_tms ? tap_pkg::UPDATE_DR  : tap_pkg::SHIFT_DR;
            tap_pkg::UPDATE_DR:  state_d = i_ftap_tms ? tap_pkg::SELECT_DR  : tap_pkg::RTI;
            // IR column, TMS high from Select-IR goes back to reset
            tap_pkg::SELECT_IR:  state_d = i_ftap_tms ? tap_pkg::TLR        : tap_pkg::CAPTURE_IR;
            tap_pkg::CAPTURE_IR: state_d = i_ftap_tms ? tap_pkg::EXIT1_IR   : tap_pkg::SHIFT_IR;
            tap_pkg::SHIFT_IR:   state_d = i_ftap_tms ? tap_pkg::EXIT1_IR   : tap_pkg::SHIFT_IR;
            tap_pkg::EXIT1_IR:   state_d = i_ftap_tms ? tap_pkg::UPDATE_IR  : tap_pkg::PAUSE_IR;
            tap_pkg::PAUSE_IR:   state_d = i_ftap_tms ? tap_pkg::EXIT2_IR   : tap_pkg::PAUSE_IR;
            tap_pkg::EXIT2_IR:   state_d = i_ftap_tms ? tap_pkg::UPDATE_IR  : tap_pkg::SHIFT_IR;
            tap_pkg::UPDATE_IR:  state_d = i_ftap_tms ? tap_pkg::SELECT_DR  : tap_pkg::RTI;
            default:             state_d = tap_pkg::TLR;
        endcase
    end

    // State register, async reset acts as TRST
    always_ff @(posedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= tap_pkg::TLR;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Strobe decode
    // ------------------------------
    // Registers act on the edge that leaves each state
    always_comb begin
        o_ctrl.tlr        = (state_q == tap_pkg::TLR);
        o_ctrl.capture_ir = (state_q == tap_pkg::CAPTURE_IR);
        o_ctrl.shift_ir   = (state_q == tap_pkg::SHIFT_IR);
        o_ctrl.update_ir  = (state_q == tap_pkg::UPDATE_IR);
        o_ctrl.capture_dr = (state_q == tap_pkg::CAPTURE_DR);
        o_ctrl.shift_dr   = (state_q == tap_pkg::SHIFT_DR);
        o_ctrl.update_dr  = (state_q == tap_pkg::UPDATE_DR);
    end

    assign o_state = state_q;

    // Only one chain may drive TDO at a time
    a_shift_excl: assert property (@(posedge i_ftap_tck) disable iff (!i_rst_n)
        !(o_ctrl.shift_dr && o_ctrl.shift_ir));

    // Five TMS-high edges reach reset from anywhere
    a_tms_reset: assert property (@(posedge i_ftap_tck) disable iff (!i_rst_n)
        i_ftap_tms [*5] |=> (o_state == tap_pkg::TLR));

endmodule

// ==== source/tap_ir.sv ====
// Instruction register and decoder
// Captures the fixed IR pattern, shifts the new opcode in from TDI and
// decodes it at Update-IR into the active data register, with the
// secure TDR gated by the security grant

`timescale 1ns/1ps
`include "stap_config.svh"

module tap_ir (
    input  logic               i_ftap_tck,
    input  logic               i_rst_n,
    input  logic               i_ftap_tdi,
    input  tap_pkg::tap_ctrl_t i_ctrl,
    input  logic               i_sec_grant,
    output logic               o_ir_tdo,
    output tap_pkg::dr_sel_t   o_dr_sel
);

    // Shift stage of the instruction register
    tap_pkg::ir_code_t ir_shift_q;

    // ------------------------------
    // Opcode decode
    // ------------------------------
    function automatic tap_pkg::dr_sel_t decode_ir(tap_pkg::ir_code_t code, logic grant);
        tap_pkg::dr_sel_t sel;
        case (code)
            `STAP_IR_IDCODE: sel = tap_pkg::IDCODE;
            `STAP_IR_TDR:    sel = tap_pkg::TDR;
            // Secure TDR only under grant, else it looks like bypass
            `STAP_IR_SECTDR: sel = grant ? tap_pkg::SECTDR : tap_pkg::BYPASS;
            `STAP_IR_BYPASS: sel = tap_pkg::BYPASS;
            default:         sel = tap_pkg::BYPASS;
        endcase
        return sel;
    endfunction

    // Shift stage, no reset needed since capture always precedes shift
    always_ff @(posedge i_ftap_tck) begin
        if (i_ctrl.capture_ir) begin
            ir_shift_q <= `STAP_IR_CAPTURE;
        end else if (i_ctrl.shift_ir) begin
            // TDI enters at the MSB, LSB leaves on TDO
            ir_shift_q <= {i_ftap_tdi, ir_shift_q[`STAP_IR_W-1:1]};
        end
    end

    assign o_ir_tdo = ir_shift_q[0];

    // Update stage holds the decoded selection
    always_ff @(posedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dr_sel <= tap_pkg::IDCODE;
        end else if (i_ctrl.tlr) begin
            // Test-Logic-Reset defaults to IDCODE
            o_dr_sel <= tap_pkg::IDCODE;
        end else if (i_ctrl.update_ir) begin
            // Grant is only looked at here
            o_dr_sel <= decode_ir(ir_shift_q, i_sec_grant);
        end
    end

    // No secure selection unless granted at that update
    a_sectdr_gated: assert property (@(posedge i_ftap_tck) disable iff (!i_rst_n)
        (i_ctrl.update_ir && !i_sec_grant) |=> (o_dr_sel != tap_pkg::SECTDR));

endmodule

// ==== source/stap_dfxsecure_plugin.sv ====
// DFx secure plug-in
// Latches the secure policy from the fuse controller, tracks early-boot
// exit and produces the registered grant for the secure TDR

`timescale 1ns/1ps

module stap_dfxsecure_plugin (
    input  logic             i_ftap_tck,
    input  logic             i_rst_n,
    input  dfx_pkg::policy_t i_fdfx_secure_policy,
    input  logic             i_fdfx_policy_update,
    input  logic             i_fdfx_earlyboot_exit,
    output logic             o_sec_grant
);

    dfx_pkg::policy_t policy_q;
    logic             earlyboot_q;
    logic             grant_d;

    // ------------------------------
    // Policy and early-boot state
    // ------------------------------
    always_ff @(posedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            policy_q    <= dfx_pkg::LOCKED;
            earlyboot_q <= 1'b0;
        end else begin
            if (i_fdfx_policy_update) begin
                policy_q <= i_fdfx_secure_policy;
            end
            // Sticky until the next reset
            if (i_fdfx_earlyboot_exit) begin
                earlyboot_q <= 1'b1;
            end
        end
    end

    // Open during early boot, then only for the open policies
    assign grant_d = !earlyboot_q
                   || (policy_q == dfx_pkg::UNLOCKED)
                   || (policy_q == dfx_pkg::MANUFACTURING);

    // Grant lags the latched policy by one cycle
    always_ff @(posedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sec_grant <= 1'b0;
        end else begin
            o_sec_grant <= grant_d;
        end
    end

    // Locked after exit keeps the grant closed while the policy holds
    a_locked_closed: assert property (@(posedge i_ftap_tck) disable iff (!i_rst_n)
        (earlyboot_q && (policy_q == dfx_pkg::LOCKED) && !i_fdfx_policy_update)
        |=> !o_sec_grant ##1 !o_sec_grant);

endmodule

// ==== source/tap_dr_shift.sv ====
// Generic test data register
// Capture, shift and update stages for one selectable data register,
// with the payload layout given by a type parameter

`timescale 1ns/1ps

module tap_dr_shift #(
    parameter type T = logic [31:0]
) (
    input  logic               i_ftap_tck,
    input  logic               i_rst_n,
    input  logic               i_ftap_tdi,
    input  logic               i_sel,
    input  tap_pkg::tap_ctrl_t i_ctrl,
    input  T                   i_capture_val,
    output logic               o_tdo,
    output T                   o_update_val
);

    localparam int W = $bits(T);

    logic [W-1:0] shift_q;

    // ------------------------------
    // Shift stage
    // ------------------------------
    // Payload only, loaded at capture before any shift
    always_ff @(posedge i_ftap_tck) begin
        if (i_sel && i_ctrl.capture_dr) begin
            shift_q <= i_capture_val;
        end else if (i_sel && i_ctrl.shift_dr) begin
            // LSB first out, TDI in at the top
            shift_q <= {i_ftap_tdi, shift_q[W-1:1]};
        end
    end

    assign o_tdo = shift_q[0];

    // ------------------------------
    // Update stage
    // ------------------------------
    // Parallel output, cleared at reset
    always_ff @(posedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_update_val <= T'('0);
        end else if (i_sel && i_ctrl.update_dr) begin
            o_update_val <= T'(shift_q);
        end
    end

endmodule

// ==== source/stap.sv ====
// Secure test access port, top level
// Primary JTAG port with IDCODE, bypass, a parallel TDR and a secure
// TDR gated by the DFx secure plug-in. TDO leaves on the falling edge

`timescale 1ns/1ps

module stap (
    input  logic               i_ftap_tck,
    input  logic               i_rst_n,
    input  logic               i_ftap_tms,
    input  logic               i_ftap_tdi,
    input  logic [31:0]        i_ftap_slvidcode,
    input  dfx_pkg::tdr_data_t i_tdr_data_in,
    input  dfx_pkg::policy_t   i_fdfx_secure_policy,
    input  logic               i_fdfx_policy_update,
    input  logic               i_fdfx_earlyboot_exit,
    output logic               o_atap_tdo,
    output logic               o_atap_tdoen,
    output dfx_pkg::tdr_data_t o_tdr_data_out,
    output dfx_pkg::sectdr_t   o_sectdr_out
);

    tap_pkg::tap_ctrl_t  ctrl;
    tap_pkg::dr_sel_t    dr_sel;
    logic                sec_grant;
    logic                ir_tdo;
    logic                idcode_tdo;
    logic                tdr_tdo;
    logic                sectdr_tdo;
    logic                bypass_q;
    logic                tdo_mux;

    // ------------------------------
    // Controller and instruction
    // ------------------------------
    tap_fsm i_tap_fsm (
        .i_ftap_tck (i_ftap_tck),
        .i_rst_n    (i_rst_n),
        .i_ftap_tms (i_ftap_tms),
        .o_state    (),
        .o_ctrl     (ctrl)
    );

    stap_dfxsecure_plugin i_stap_dfxsecure_plugin (
        .i_ftap_tck            (i_ftap_tck),
        .i_rst_n               (i_rst_n),
        .i_fdfx_secure_policy  (i_fdfx_secure_policy),
        .i_fdfx_policy_update  (i_fdfx_policy_update),
        .i_fdfx_earlyboot_exit (i_fdfx_earlyboot_exit),
        .o_sec_grant           (sec_grant)
    );

    tap_ir i_tap_ir (
        .i_ftap_tck  (i_ftap_tck),
        .i_rst_n     (i_rst_n),
        .i_ftap_tdi  (i_ftap_tdi),
        .i_ctrl      (ctrl),
        .i_sec_grant (sec_grant),
        .o_ir_tdo    (ir_tdo),
        .o_dr_sel    (dr_sel)
    );

    // ------------------------------
    // Data registers
    // ------------------------------
    // ID code is capture only with no parallel output
    tap_dr_shift #(.T(logic [31:0])) i_idcode_dr (
        .i_ftap_tck    (i_ftap_tck),
        .i_rst_n       (i_rst_n),
        .i_ftap_tdi    (i_ftap_tdi),
        .i_sel         (dr_sel == tap_pkg::IDCODE),
        .i_ctrl        (ctrl),
        .i_capture_val (i_ftap_slvidcode),
        .o_tdo         (idcode_tdo),
        .o_update_val  ()
    );

    tap_dr_shift #(.T(dfx_pkg::tdr_data_t)) i_tdr_dr (
        .i_ftap_tck    (i_ftap_tck),
        .i_rst_n       (i_rst_n),
        .i_ftap_tdi    (i_ftap_tdi),
        .i_sel         (dr_sel == tap_pkg::TDR),
        .i_ctrl        (ctrl),
        .i_capture_val (i_tdr_data_in),
        .o_tdo         (tdr_tdo),
        .o_update_val  (o_tdr_data_out)
    );

    // Reads back its own last written value
    tap_dr_shift #(.T(dfx_pkg::sectdr_t)) i_sectdr_dr (
        .i_ftap_tck    (i_ftap_tck),
        .i_rst_n       (i_rst_n),
        .i_ftap_tdi    (i_ftap_tdi),
        .i_sel         (dr_sel == tap_pkg::SECTDR),
        .i_ctrl        (ctrl),
        .i_capture_val (o_sectdr_out),
        .o_tdo         (sectdr_tdo),
        .o_update_val  (o_sectdr_out)
    );

    // Bypass cell captures 0 then passes TDI through one stage
    always_ff @(posedge i_ftap_tck) begin
        if (dr_sel == tap_pkg::BYPASS) begin
            if (ctrl.capture_dr) begin
                bypass_q <= 1'b0;
            end else if (ctrl.shift_dr) begin
                bypass_q <= i_ftap_tdi;
            end
        end
    end

    // ------------------------------
    // TDO path
    // ------------------------------
    always_comb begin
        if (ctrl.shift_ir) begin
            tdo_mux = ir_tdo;
        end else begin
            case (dr_sel)
                tap_pkg::IDCODE: tdo_mux = idcode_tdo;
                tap_pkg::TDR:    tdo_mux = tdr_tdo;
                tap_pkg::SECTDR: tdo_mux = sectdr_tdo;
                default:         tdo_mux = bypass_q;
            endcase
        end
    end

    // Retimed to the falling edge and holds its last bit outside shift
    always_ff @(negedge i_ftap_tck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_atap_tdo   <= 1'b0;
            o_atap_tdoen <= 1'b0;
        end else begin
            o_atap_tdoen <= ctrl.shift_dr || ctrl.shift_ir;
            if (ctrl.shift_dr || ctrl.shift_ir) begin
                o_atap_tdo <= tdo_mux;
            end
        end
    end

endmodule

// ==== dv/stap_tb.sv ====
// Testbench for the secure TAP
// Drives the primary JTAG port through IDCODE, bypass, the general TDR
// and the secure TDR under a changing security policy. Every scan is
// checked against a reference model of the expected shift-out

`timescale 1ns/1ps
`include "stap_config.svh"

module stap_tb;

    localparam int          DRAIN_TIMEOUT = 20;
    localparam logic [31:0] SEED          = 32'd75;

    logic               i_ftap_tck;
    logic               i_rst_n;
    logic               i_ftap_tms;
    logic               i_ftap_tdi;
    logic [31:0]        i_ftap_slvidcode;
    dfx_pkg::tdr_data_t i_tdr_data_in;
    dfx_pkg::policy_t   i_fdfx_secure_policy;
    logic               i_fdfx_policy_update;
    logic               i_fdfx_earlyboot_exit;
    logic               o_atap_tdo;
    logic               o_atap_tdoen;
    dfx_pkg::tdr_data_t o_tdr_data_out;
    dfx_pkg::sectdr_t   o_sectdr_out;

    // One finished scan, handed to the checker
    typedef struct packed {
        logic             is_ir;
        tap_pkg::dr_sel_t sel;
        int               len;
        logic [63:0]      exp;
        logic [63:0]      act;
    } scan_rec_t;

    scan_rec_t          scan_q[$];
    logic [31:0]        rng_state;

    // Reference model state
    tap_pkg::dr_sel_t   model_sel;
    dfx_pkg::tdr_data_t model_tdr_in;
    dfx_pkg::sectdr_t   model_sectdr;
    dfx_pkg::policy_t   model_policy;
    logic               model_exit;

    stap i_dut (
        .i_ftap_tck            (i_ftap_tck),
        .i_rst_n               (i_rst_n),
        .i_ftap_tms            (i_ftap_tms),
        .i_ftap_tdi            (i_ftap_tdi),
        .i_ftap_slvidcode      (i_ftap_slvidcode),
        .i_tdr_data_in         (i_tdr_data_in),
        .i_fdfx_secure_policy  (i_fdfx_secure_policy),
        .i_fdfx_policy_update  (i_fdfx_policy_update),
        .i_fdfx_earlyboot_exit (i_fdfx_earlyboot_exit),
        .o_atap_tdo            (o_atap_tdo),
        .o_atap_tdoen          (o_atap_tdoen),
        .o_tdr_data_out        (o_tdr_data_out),
        .o_sectdr_out          (o_sectdr_out)
    );

    // 8 ns TCK
    always #4 i_ftap_tck = ~i_ftap_tck;

    // ------------------------------
    // Random source and reporting
    // ------------------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic idcode_compare(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        if (act !== exp) begin
            $display("Error: time %0t, signal %s, expected %h, actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic tdr_compare(input string name, input dfx_pkg::tdr_data_t exp,
                               input dfx_pkg::tdr_data_t act);
        if (act !== exp) begin
            $display("Error: time %0t, signal %s, expected %h, actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic sectdr_compare(input string name, input dfx_pkg::sectdr_t exp,
                                  input dfx_pkg::sectdr_t act);
        if (act !== exp) begin
            $display("Error: time %0t, signal %s, expected %h, actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic bit_compare(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: time %0t, signal %s, expected %b, actual %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    // Decode as seen at Update-IR, grant from early boot and policy
    function automatic tap_pkg::dr_sel_t expected_sel(input tap_pkg::ir_code_t code);
        logic             grant;
        tap_pkg::dr_sel_t sel;
        grant = !model_exit || (model_policy == dfx_pkg::UNLOCKED)
              || (model_policy == dfx_pkg::MANUFACTURING);
        if (code == `STAP_IR_IDCODE) begin
            sel = tap_pkg::IDCODE;
        end else if (code == `STAP_IR_TDR) begin
            sel = tap_pkg::TDR;
        end else if ((code == `STAP_IR_SECTDR) && grant) begin
            sel = tap_pkg::SECTDR;
        end else begin
            sel = tap_pkg::BYPASS;
        end
        return sel;
    endfunction

    // Captured bits leave first, then the TDI bits follow them out
    function automatic logic [63:0] expected_scan(input tap_pkg::dr_sel_t sel,
                                                  input logic [63:0] tdi, input int n);
        logic [63:0] cap;
        logic [63:0] res;
        int          w;
        int          i;
        case (sel)
            tap_pkg::IDCODE: begin
                cap = {32'h0, i_ftap_slvidcode};
                w   = 32;
            end
            tap_pkg::TDR: begin
                cap = {48'h0, model_tdr_in};
                w   = 16;
            end
            tap_pkg::SECTDR: begin
                cap = {56'h0, model_sectdr};
                w   = 8;
            end
            default: begin
                // Bypass cell, a single 0
                cap = '0;
                w   = 1;
            end
        endcase
        res = '0;
        for (i = 0; i < n; i++) begin
            if (i < w) begin
                res[i] = cap[i];
            end else begin
                res[i] = tdi[i - w];
            end
        end
        return res;
    endfunction

    // ------------------------------
    // Checker
    // ------------------------------
    always @(posedge i_ftap_tck) begin : compare_scans
        scan_rec_t rec;
        int        i;
        if (scan_q.size() > 0) begin
            rec = scan_q.pop_front();
            if (rec.is_ir) begin
                for (i = 0; i < rec.len; i++) begin
                    bit_compare($sformatf("o_atap_tdo ir bit %0d", i), rec.exp[i], rec.act[i]);
                end
            end else begin
                case (rec.sel)
                    tap_pkg::IDCODE: idcode_compare("o_atap_tdo idcode",
                                                    rec.exp[31:0], rec.act[31:0]);
                    tap_pkg::TDR: tdr_compare("o_atap_tdo tdr",
                                              dfx_pkg::tdr_data_t'(rec.exp[15:0]),
                                              dfx_pkg::tdr_data_t'(rec.act[15:0]));
                    tap_pkg::SECTDR: sectdr_compare("o_atap_tdo sectdr",
                                                    dfx_pkg::sectdr_t'(rec.exp[7:0]),
                                                    dfx_pkg::sectdr_t'(rec.act[7:0]));
                    default: begin
                        for (i = 0; i < rec.len; i++) begin
                            bit_compare($sformatf("o_atap_tdo bypass bit %0d", i),
                                        rec.exp[i], rec.act[i]);
                        end
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // JTAG driver
    // ------------------------------
    // One TCK cycle, entered on a rising edge; tdoen must match the state
    task automatic tck_step(input logic tms, input logic tdi, input logic exp_en,
                            output logic tdo);
        i_ftap_tms <= tms;
        i_ftap_tdi <= tdi;
        @(posedge i_ftap_tck);
        tdo = o_atap_tdo;
        bit_compare("o_atap_tdoen", exp_en, o_atap_tdoen);
    endtask

    task automatic idle_cycles(input int n);
        logic bit_out;
        int   i;
        for (i = 0; i < n; i++) begin
            tck_step(1'b0, 1'b0, 1'b0, bit_out);
        end
    endtask

    // Run-Test/Idle to Run-Test/Idle through the IR column
    task automatic load_ir(input tap_pkg::ir_code_t code);
        logic      bit_out;
        int        i;
        scan_rec_t rec;
        rec.act = '0;
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < `STAP_IR_W; i++) begin
            tck_step(i == `STAP_IR_W - 1, code[i], 1'b1, bit_out);
            rec.act[i] = bit_out;
        end
        // Exit1-IR, then Update-IR
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        rec.is_ir = 1'b1;
        rec.sel   = model_sel;
        rec.len   = `STAP_IR_W;
        rec.exp   = {60'h0, `STAP_IR_CAPTURE};
        scan_q.push_back(rec);
        model_sel = expected_sel(code);
    endtask

    // Run-Test/Idle to Run-Test/Idle through the DR column
    task automatic scan_dr(input int n, input logic [63:0] tdi, output logic [63:0] tdo);
        logic      bit_out;
        int        i;
        scan_rec_t rec;
        tdo = '0;
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < n; i++) begin
            tck_step(i == n - 1, tdi[i], 1'b1, bit_out);
            tdo[i] = bit_out;
        end
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        rec.is_ir = 1'b0;
        rec.sel   = model_sel;
        rec.len   = n;
        rec.exp   = expected_scan(model_sel, tdi, n);
        rec.act   = tdo;
        scan_q.push_back(rec);
    endtask

    // Shift a few bits, then five TMS-high cycles into Test-Logic-Reset
    task automatic abort_scan(input int n);
        logic bit_out;
        int   i;
        tck_step(1'b1, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < n; i++) begin
            tck_step(1'b0, 1'b1, 1'b1, bit_out);
        end
        // Still in Shift-DR on the first high cycle
        tck_step(1'b1, 1'b0, 1'b1, bit_out);
        for (i = 0; i < 4; i++) begin
            tck_step(1'b1, 1'b0, 1'b0, bit_out);
        end
        model_sel = tap_pkg::IDCODE;
    endtask

    task automatic apply_policy(input dfx_pkg::policy_t p, input logic exit_boot);
        i_fdfx_secure_policy  <= p;
        i_fdfx_policy_update  <= 1'b1;
        i_fdfx_earlyboot_exit <= exit_boot;
        idle_cycles(1);
        i_fdfx_policy_update  <= 1'b0;
        i_fdfx_earlyboot_exit <= 1'b0;
        // Grant settles two cycles after the latch
        idle_cycles(3);
        model_policy = p;
        if (exit_boot) begin
            model_exit = 1'b1;
        end
    endtask

    task automatic drain_checks();
        int waited;
        waited = 0;
        while ((scan_q.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
            @(posedge i_ftap_tck);
            waited++;
        end
        if (scan_q.size() != 0) begin
            $display("Timeout: the checker left %0d scan results unchecked", scan_q.size());
            stop_on_error();
        end
    endtask

    task automatic run_random_scans(input int count);
        logic [63:0] vec;
        logic [63:0] res;
        int          n;
        int          i;
        for (i = 0; i < count; i++) begin
            n   = 4 + int'(xorshift32() % 17);
            vec = {xorshift32(), xorshift32()};
            scan_dr(n, vec, res);
            drain_checks();
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : test_sequence
        logic [63:0]      vec;
        logic [63:0]      res;
        logic [31:0]      r;
        dfx_pkg::sectdr_t wr;
        int               i;
        i_ftap_tck            = 1'b0;
        i_rst_n               = 1'b0;
        i_ftap_tms            = 1'b1;
        i_ftap_tdi            = 1'b0;
        i_ftap_slvidcode      = `STAP_RESET_IDCODE;
        i_tdr_data_in         = '0;
        i_fdfx_secure_policy  = dfx_pkg::LOCKED;
        i_fdfx_policy_update  = 1'b0;
        i_fdfx_earlyboot_exit = 1'b0;
        rng_state             = SEED;
        model_sel             = tap_pkg::IDCODE;
        model_tdr_in          = '0;
        model_sectdr          = '0;
        model_policy          = dfx_pkg::LOCKED;
        model_exit            = 1'b0;

        repeat (2) @(posedge i_ftap_tck);
        i_rst_n <= 1'b1;
        // Test-Logic-Reset to Run-Test/Idle
        idle_cycles(1);
        tdr_compare("o_tdr_data_out", '0, o_tdr_data_out);
        sectdr_compare("o_sectdr_out", '0, o_sectdr_out);

        // ID code straight out of reset, then the IR capture pattern
        vec = {xorshift32(), xorshift32()};
        scan_dr(32, vec, res);
        drain_checks();
        load_ir(`STAP_IR_IDCODE);
        drain_checks();

        // Bypass and undefined codes
        load_ir(`STAP_IR_BYPASS);
        run_random_scans(3);
        load_ir(4'b0110);
        run_random_scans(2);
        load_ir(4'b1010);
        run_random_scans(2);

        // General TDR, capture from the pins and parallel update
        load_ir(`STAP_IR_TDR);
        drain_checks();
        for (i = 0; i < 2; i++) begin
            r             = xorshift32();
            model_tdr_in  = dfx_pkg::tdr_data_t'(r[15:0]);
            i_tdr_data_in <= model_tdr_in;
            vec           = {xorshift32(), xorshift32()};
            scan_dr(16, vec, res);
            idle_cycles(1);
            tdr_compare("o_tdr_data_out", dfx_pkg::tdr_data_t'(vec[15:0]), o_tdr_data_out);
            drain_checks();
        end

        // Secure TDR open during early boot
        load_ir(`STAP_IR_SECTDR);
        drain_checks();
        for (i = 0; i < 2; i++) begin
            r  = xorshift32();
            wr = dfx_pkg::sectdr_t'(r[7:0]);
            scan_dr(8, {56'h0, wr}, res);
            idle_cycles(1);
            sectdr_compare("o_sectdr_out", wr, o_sectdr_out);
            drain_checks();
            model_sectdr = wr;
        end

        // Exit with a locked policy, the secure code falls back to bypass
        apply_policy(dfx_pkg::LOCKED, 1'b1);
        load_ir(`STAP_IR_SECTDR);
        drain_checks();
        vec = {xorshift32(), xorshift32()};
        scan_dr(8, vec, res);
        idle_cycles(1);
        sectdr_compare("o_sectdr_out", model_sectdr, o_sectdr_out);
        drain_checks();

        // Unlocked again, readback of the last write then a new one
        apply_policy(dfx_pkg::UNLOCKED, 1'b0);
        load_ir(`STAP_IR_SECTDR);
        drain_checks();
        r  = xorshift32();
        wr = dfx_pkg::sectdr_t'(r[7:0]);
        scan_dr(8, {56'h0, wr}, res);
        idle_cycles(1);
        sectdr_compare("o_sectdr_out", wr, o_sectdr_out);
        drain_checks();
        model_sectdr = wr;

        // Controller reset in the middle of a scan
        load_ir(`STAP_IR_BYPASS);
        drain_checks();
        abort_scan(3);
        idle_cycles(1);
        vec = {xorshift32(), xorshift32()};
        scan_dr(32, vec, res);
        drain_checks();

        $display("sim passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+source
source/tap_pkg.sv
source/dfx_pkg.sv
source/tap_fsm.sv
source/tap_ir.sv
source/stap_dfxsecure_plugin.sv
source/tap_dr_shift.sv
source/stap.sv
dv/stap_tb.sv

// ==== Makefile ====
# Verilator flow for the secure TAP

TOP := stap_tb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)

# Pass only if the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing --top-module stap -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
